// ==== logic/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    // data and address words
    typedef logic [31:0] word_t;

    // instruction funct3 field
    typedef logic [2:0] funct3_t;

    // one enable per byte lane of a word
    typedef logic [3:0] byte_en_t;

    // byte position inside a word
    typedef logic [1:0] byte_off_t;

    // load widths as encoded in funct3
    typedef enum logic [2:0]
    {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // store widths as encoded in funct3
    typedef enum logic [2:0]
    {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // data RAM depth in words
    localparam int RAM_WORDS = 256;
    localparam int RAM_INDEX_W = $clog2(RAM_WORDS);

    // word index, taken from address bits above the byte offset
    typedef logic [RAM_INDEX_W-1:0] ram_index_t;

endpackage

`default_nettype wire

// ==== logic/mem_ctrl_stage.sv ====
`default_nettype none

module mem_ctrl_stage
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ex_valid,
    input  logic                   ex_load,
    input  logic                   ex_store,
    input  rv32i_types::funct3_t   ex_funct3,
    input  rv32i_types::byte_off_t addr_low,
    output logic                   load_data_out,
    output logic                   data_read,
    output logic                   data_write,
    output logic                   load_data_value,
    output logic                   mem_valid,
    output logic                   mem_fault,
    output rv32i_types::funct3_t   funct3_mem
);

    logic access;
    logic known_width;
    logic misaligned;
    logic fault;

    // width decode and alignment rule
    always_comb
    begin
        known_width = 1'b0;
        misaligned = 1'b0;
        if (ex_load)
        begin
            case (ex_funct3)
                rv32i_types::lb, rv32i_types::lbu:
                    known_width = 1'b1;
                rv32i_types::lh, rv32i_types::lhu:
                begin
                    known_width = 1'b1;
                    misaligned = addr_low[0];
                end
                rv32i_types::lw:
                begin
                    known_width = 1'b1;
                    misaligned = |addr_low;
                end
                default:
                    known_width = 1'b0;
            endcase
        end
        else
        begin
            case (ex_funct3)
                rv32i_types::sb:
                    known_width = 1'b1;
                rv32i_types::sh:
                begin
                    known_width = 1'b1;
                    misaligned = addr_low[0];
                end
                rv32i_types::sw:
                begin
                    known_width = 1'b1;
                    misaligned = |addr_low;
                end
                default:
                    known_width = 1'b0;
            endcase
        end
    end

    assign access = ex_valid && (ex_load || ex_store);
    assign fault = access && (!known_width || misaligned);

    // enables the store data register one stage ahead
    assign load_data_out = ex_valid && ex_store && !fault;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            data_read <= 1'b0;
            data_write <= 1'b0;
            load_data_value <= 1'b0;
            mem_valid <= 1'b0;
            mem_fault <= 1'b0;
            funct3_mem <= '0;
        end
        else
        begin
            data_read <= ex_valid && ex_load && !fault;
            data_write <= load_data_out;
            load_data_value <= ex_valid && ex_load;
            mem_valid <= access;
            mem_fault <= fault;
            funct3_mem <= ex_funct3;
        end
    end

    // execute hands over one kind of access at a time
    assert property (@(posedge clk) disable iff (rst) ex_valid |-> !(ex_load && ex_store));

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`default_nettype none

module mem_stage
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_data_out,
    input  logic                   load_data_value,
    input  rv32i_types::funct3_t   funct3_exec,
    input  rv32i_types::funct3_t   funct3_mem,
    input  rv32i_types::word_t     alu_out,
    input  rv32i_types::word_t     rs2_out,
    input  rv32i_types::word_t     mem_rdata,
    output rv32i_types::word_t     mem_address,
    output rv32i_types::word_t     mem_wdata,
    output rv32i_types::word_t     data_value,
    output rv32i_types::byte_off_t mem_address_last_two_bits,
    output rv32i_types::byte_en_t  mem_byte_enable
);

    rv32i_types::word_t address_q;
    rv32i_types::word_t store_lanes;

    // RAM sees word addresses only
    assign mem_address = {address_q[31:2], 2'b00};
    assign mem_address_last_two_bits = address_q[1:0];

    // steering happens in execute, before the address is registered
    always_comb
    begin
        case (funct3_exec)
            rv32i_types::sw:
                store_lanes = rs2_out;
            rv32i_types::sh:
            begin
                if (alu_out[1])
                    store_lanes = {rs2_out[15:0], 16'b0};
                else
                    store_lanes = {16'b0, rs2_out[15:0]};
            end
            rv32i_types::sb:
            begin
                case (alu_out[1:0])
                    2'b00: store_lanes = {24'b0, rs2_out[7:0]};
                    2'b01: store_lanes = {16'b0, rs2_out[7:0], 8'b0};
                    2'b10: store_lanes = {8'b0, rs2_out[7:0], 16'b0};
                    default: store_lanes = {rs2_out[7:0], 24'b0};
                endcase
            end
            default:
                store_lanes = rs2_out;
        endcase
    end

    // lane enables from the memory-stage width and offset
    always_comb
    begin
        case (funct3_mem)
            rv32i_types::sw:
                mem_byte_enable = 4'b1111;
            rv32i_types::sh:
            begin
                if (mem_address_last_two_bits[1])
                    mem_byte_enable = 4'b1100;
                else
                    mem_byte_enable = 4'b0011;
            end
            rv32i_types::sb:
            begin
                case (mem_address_last_two_bits)
                    2'b00: mem_byte_enable = 4'b0001;
                    2'b01: mem_byte_enable = 4'b0010;
                    2'b10: mem_byte_enable = 4'b0100;
                    default: mem_byte_enable = 4'b1000;
                endcase
            end
            default:
                mem_byte_enable = 4'b1111;
        endcase
    end

    // address follows execute every cycle
    always_ff @(posedge clk)
    begin
        if (rst)
            address_q <= '0;
        else
            address_q <= alu_out;
    end

    // store data, loaded only for a clean store
    always_ff @(posedge clk)
    begin
        if (rst)
            mem_wdata <= '0;
        else if (load_data_out)
            mem_wdata <= store_lanes;
    end

    // read data held for the writeback side
    always_ff @(posedge clk)
    begin
        if (rst)
            data_value <= '0;
        else if (load_data_value)
            data_value <= mem_rdata;
    end

    assert property (@(posedge clk) disable iff (rst) mem_byte_enable != '0);

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`default_nettype none

module data_ram
(
    input  logic                  clk,
    input  logic                  data_write,
    input  logic                  data_read,
    input  rv32i_types::word_t    mem_address,
    input  rv32i_types::word_t    mem_wdata,
    input  rv32i_types::byte_en_t mem_byte_enable,
    output rv32i_types::word_t    mem_rdata
);

    rv32i_types::word_t mem [rv32i_types::RAM_WORDS];
    rv32i_types::ram_index_t index;

    // bits above the RAM depth wrap onto the same words
    assign index = mem_address[2 +: rv32i_types::RAM_INDEX_W];

    // read port is combinational, quiet when no load is in flight
    assign mem_rdata = data_read ? mem[index] : '0;

    always_ff @(posedge clk)
    begin
        if (data_write)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (mem_byte_enable[lane])
                    mem[index][8*lane +: 8] <= mem_wdata[8*lane +: 8];
            end
        end
    end

    // control stage never issues both in one cycle
    assert property (@(posedge clk) !(data_read && data_write));

endmodule

`default_nettype wire

// ==== logic/writeback_align.sv ====
`default_nettype none

module writeback_align
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_valid,
    input  logic                   mem_fault,
    input  logic                   data_read,
    input  rv32i_types::funct3_t   funct3_mem,
    input  rv32i_types::byte_off_t byte_off,
    input  rv32i_types::word_t     data_value,
    output logic                   wb_done,
    output logic                   wb_fault,
    output rv32i_types::word_t     wb_data
);

    // control delayed to line up with data_value
    logic                   valid_q;
    logic                   fault_q;
    logic                   load_q;
    rv32i_types::funct3_t   funct3_q;
    rv32i_types::byte_off_t off_q;

    logic [7:0]         sel_byte;
    logic [15:0]        sel_half;
    rv32i_types::word_t extended;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
            fault_q <= 1'b0;
            load_q <= 1'b0;
            funct3_q <= '0;
            off_q <= '0;
        end
        else
        begin
            valid_q <= mem_valid;
            fault_q <= mem_fault;
            load_q <= data_read;
            funct3_q <= funct3_mem;
            off_q <= byte_off;
        end
    end

    assign sel_byte = data_value[{off_q, 3'b000} +: 8];
    assign sel_half = data_value[{off_q[1], 4'b0000} +: 16];

    // sign for lb and lh, zero for the unsigned forms
    always_comb
    begin
        case (funct3_q)
            rv32i_types::lb:  extended = {{24{sel_byte[7]}}, sel_byte};
            rv32i_types::lbu: extended = {24'b0, sel_byte};
            rv32i_types::lh:  extended = {{16{sel_half[15]}}, sel_half};
            rv32i_types::lhu: extended = {16'b0, sel_half};
            default:          extended = data_value;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_done <= 1'b0;
            wb_fault <= 1'b0;
            wb_data <= '0;
        end
        else
        begin
            wb_done <= valid_q;
            wb_fault <= valid_q && fault_q;
            // stores and faulted accesses report zero
            wb_data <= load_q ? extended : '0;
        end
    end

    // a load that reached the RAM was never flagged as faulting upstream
    assert property (@(posedge clk) disable iff (rst) load_q |-> !fault_q && valid_q);

endmodule

`default_nettype wire

// ==== logic/mem_access_top.sv ====
`default_nettype none

module mem_access_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  logic                 ex_load,
    input  logic                 ex_store,
    input  rv32i_types::funct3_t ex_funct3,
    input  rv32i_types::word_t   alu_out,
    input  rv32i_types::word_t   rs2_out,
    output logic                 wb_done,
    output logic                 wb_fault,
    output rv32i_types::word_t   wb_data
);

    logic                   load_data_out;
    logic                   data_read;
    logic                   data_write;
    logic                   load_data_value;
    logic                   mem_valid;
    logic                   mem_fault;
    rv32i_types::funct3_t   funct3_mem;
    rv32i_types::word_t     mem_address;
    rv32i_types::word_t     mem_wdata;
    rv32i_types::word_t     mem_rdata;
    rv32i_types::word_t     data_value;
    rv32i_types::byte_off_t mem_address_last_two_bits;
    rv32i_types::byte_en_t  mem_byte_enable;

    mem_ctrl_stage mem_ctrl_stage_i
    (
        .clk             (clk),
        .rst             (rst),
        .ex_valid        (ex_valid),
        .ex_load         (ex_load),
        .ex_store        (ex_store),
        .ex_funct3       (ex_funct3),
        .addr_low        (alu_out[1:0]),
        .load_data_out   (load_data_out),
        .data_read       (data_read),
        .data_write      (data_write),
        .load_data_value (load_data_value),
        .mem_valid       (mem_valid),
        .mem_fault       (mem_fault),
        .funct3_mem      (funct3_mem)
    );

    mem_stage mem_stage_i
    (
        .clk                       (clk),
        .rst                       (rst),
        .load_data_out             (load_data_out),
        .load_data_value           (load_data_value),
        .funct3_exec               (ex_funct3),
        .funct3_mem                (funct3_mem),
        .alu_out                   (alu_out),
        .rs2_out                   (rs2_out),
        .mem_rdata                 (mem_rdata),
        .mem_address               (mem_address),
        .mem_wdata                 (mem_wdata),
        .data_value                (data_value),
        .mem_address_last_two_bits (mem_address_last_two_bits),
        .mem_byte_enable           (mem_byte_enable)
    );

    data_ram data_ram_i
    (
        .clk             (clk),
        .data_write      (data_write),
        .data_read       (data_read),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata)
    );

    writeback_align writeback_align_i
    (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_fault  (mem_fault),
        .data_read  (data_read),
        .funct3_mem (funct3_mem),
        .byte_off   (mem_address_last_two_bits),
        .data_value (data_value),
        .wb_done    (wb_done),
        .wb_fault   (wb_fault),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== dv/mem_access_tb.sv ====
`default_nettype none

module mem_access_tb;

    logic                 clk;
    logic                 rst;
    logic                 ex_valid;
    logic                 ex_load;
    logic                 ex_store;
    rv32i_types::funct3_t ex_funct3;
    rv32i_types::word_t   alu_out;
    rv32i_types::word_t   rs2_out;
    logic                 wb_done;
    logic                 wb_fault;
    rv32i_types::word_t   wb_data;

    // stimulus table, one entry per cycle, idle when neither load nor store
    string                op_name[$];
    bit                   op_load[$];
    bit                   op_store[$];
    rv32i_types::funct3_t op_f3[$];
    rv32i_types::word_t   op_addr[$];
    rv32i_types::word_t   op_wdata[$];
    rv32i_types::word_t   exp_data[$];
    bit                   exp_fault[$];
    int                   issue_cycle[$];

    // byte-wide reference memory, same 1 KiB window as the RAM
    logic [7:0] ref_mem [4*rv32i_types::RAM_WORDS];

    int     pending[$];
    int     cycle;
    int     errors;
    int     checked;
    int     passed;
    int     failed;
    bit     table_ready;
    integer seed;

    mem_access_top mem_access_top_i
    (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_load   (ex_load),
        .ex_store  (ex_store),
        .ex_funct3 (ex_funct3),
        .alu_out   (alu_out),
        .rs2_out   (rs2_out),
        .wb_done   (wb_done),
        .wb_fault  (wb_fault),
        .wb_data   (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic add_entry(input string name, input bit is_load, input bit is_store,
                             input rv32i_types::funct3_t f3, input rv32i_types::word_t addr,
                             input rv32i_types::word_t data);
        op_name.push_back(name);
        op_load.push_back(is_load);
        op_store.push_back(is_store);
        op_f3.push_back(f3);
        op_addr.push_back(addr);
        op_wdata.push_back(data);
        exp_data.push_back('0);
        exp_fault.push_back(1'b0);
        issue_cycle.push_back(0);
    endtask

    task automatic add_store(input string name, input rv32i_types::funct3_t f3,
                             input rv32i_types::word_t addr, input rv32i_types::word_t data);
        add_entry(name, 1'b0, 1'b1, f3, addr, data);
    endtask

    task automatic add_load(input string name, input rv32i_types::funct3_t f3,
                            input rv32i_types::word_t addr);
        add_entry(name, 1'b1, 1'b0, f3, addr, '0);
    endtask

    task automatic add_idle(input string name);
        add_entry(name, 1'b0, 1'b0, '0, '0, '0);
    endtask

    // halfwords need an even address, words a multiple of four
    function automatic bit access_faults(input bit is_load, input rv32i_types::funct3_t f3,
                                         input rv32i_types::word_t addr);
        if (f3 == 3'b000 || (is_load && f3 == 3'b100))
            return 1'b0;
        if (f3 == 3'b001 || (is_load && f3 == 3'b101))
            return addr[0];
        if (f3 == 3'b010)
            return addr[1:0] != 2'b00;
        return 1'b1;
    endfunction

    // little endian, byte at the lowest address lands in bits 7:0
    function automatic rv32i_types::word_t load_value(input rv32i_types::funct3_t f3,
                                                      input rv32i_types::word_t addr);
        logic [9:0] base;
        base = addr[9:0];
        case (f3)
            3'b000: return {{24{ref_mem[base][7]}}, ref_mem[base]};
            3'b100: return {24'b0, ref_mem[base]};
            3'b001: return {{16{ref_mem[base + 10'd1][7]}}, ref_mem[base + 10'd1], ref_mem[base]};
            3'b101: return {16'b0, ref_mem[base + 10'd1], ref_mem[base]};
            default: return {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                             ref_mem[base + 10'd1], ref_mem[base]};
        endcase
    endfunction

    task automatic store_ref(input rv32i_types::funct3_t f3, input rv32i_types::word_t addr,
                             input rv32i_types::word_t data);
        logic [9:0] base;
        base = addr[9:0];
        ref_mem[base] = data[7:0];
        if (f3 != 3'b000)
            ref_mem[base + 10'd1] = data[15:8];
        if (f3 == 3'b010)
        begin
            ref_mem[base + 10'd2] = data[23:16];
            ref_mem[base + 10'd3] = data[31:24];
        end
    endtask

    // walk the table in order so later loads see earlier stores
    task automatic build_expected();
        for (int i = 0; i < op_name.size(); i++)
        begin
            if (op_load[i] || op_store[i])
            begin
                exp_fault[i] = access_faults(op_load[i], op_f3[i], op_addr[i]);
                if (op_load[i] && !exp_fault[i])
                    exp_data[i] = load_value(op_f3[i], op_addr[i]);
                if (op_store[i] && !exp_fault[i])
                    store_ref(op_f3[i], op_addr[i], op_wdata[i]);
            end
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 3; i++)
            add_idle("idle_after_reset");
        // word round trips, 0x500 aliases 0x100
        add_store("sw_100", rv32i_types::sw, 32'h100, $random(seed));
        add_store("sw_204", rv32i_types::sw, 32'h204, $random(seed));
        add_store("sw_3fc", rv32i_types::sw, 32'h3fc, $random(seed));
        add_load("lw_100", rv32i_types::lw, 32'h100);
        add_load("lw_204", rv32i_types::lw, 32'h204);
        add_load("lw_3fc", rv32i_types::lw, 32'h3fc);
        add_load("lw_500_alias", rv32i_types::lw, 32'h500);
        add_idle("gap");
        // byte lanes and extension
        add_store("sw_40_base", rv32i_types::sw, 32'h40, 32'h1122_3344);
        add_store("sb_40", rv32i_types::sb, 32'h40, 32'hffff_ff85);
        add_store("sb_41", rv32i_types::sb, 32'h41, 32'h0000_007f);
        add_store("sb_42", rv32i_types::sb, 32'h42, 32'h1234_56c0);
        add_store("sb_43", rv32i_types::sb, 32'h43, 32'h0000_0001);
        add_load("lb_40", rv32i_types::lb, 32'h40);
        add_load("lbu_40", rv32i_types::lbu, 32'h40);
        add_load("lb_41", rv32i_types::lb, 32'h41);
        add_load("lbu_41", rv32i_types::lbu, 32'h41);
        add_load("lb_42", rv32i_types::lb, 32'h42);
        add_load("lbu_42", rv32i_types::lbu, 32'h42);
        add_load("lb_43", rv32i_types::lb, 32'h43);
        add_load("lbu_43", rv32i_types::lbu, 32'h43);
        add_load("lw_40", rv32i_types::lw, 32'h40);
        add_store("sw_48_base", rv32i_types::sw, 32'h48, 32'ha5a5_a5a5);
        add_store("sb_4a", rv32i_types::sb, 32'h4a, 32'h0000_003c);
        add_load("lw_48", rv32i_types::lw, 32'h48);
        // halfwords
        add_store("sw_80_base", rv32i_types::sw, 32'h80, $random(seed));
        add_store("sh_80", rv32i_types::sh, 32'h80, 32'h1234_8001);
        add_store("sh_82", rv32i_types::sh, 32'h82, 32'hffff_7ffe);
        add_load("lh_80", rv32i_types::lh, 32'h80);
        add_load("lhu_80", rv32i_types::lhu, 32'h80);
        add_load("lh_82", rv32i_types::lh, 32'h82);
        add_load("lhu_82", rv32i_types::lhu, 32'h82);
        add_load("lw_80", rv32i_types::lw, 32'h80);
        add_idle("gap");
        // faults must leave 0xc0 untouched
        add_store("sw_c0_base", rv32i_types::sw, 32'hc0, 32'hdead_beef);
        // other data left in the store register, so a leaked write shows at 0xc0
        add_store("sw_d0_other", rv32i_types::sw, 32'hd0, 32'h0bad_cafe);
        add_store("sw_c1_misaligned", rv32i_types::sw, 32'hc1, $random(seed));
        add_store("sw_c2_misaligned", rv32i_types::sw, 32'hc2, $random(seed));
        add_store("sh_c3_misaligned", rv32i_types::sh, 32'hc3, $random(seed));
        add_load("lw_c2_misaligned", rv32i_types::lw, 32'hc2);
        add_load("lh_c1_misaligned", rv32i_types::lh, 32'hc1);
        add_load("lhu_c3_misaligned", rv32i_types::lhu, 32'hc3);
        add_load("load_funct3_011", 3'b011, 32'hc0);
        add_store("store_funct3_100", 3'b100, 32'hc0, $random(seed));
        add_load("lw_c0_after_faults", rv32i_types::lw, 32'hc0);
        // back to back, loads right behind stores to the same word
        add_store("sw_140", rv32i_types::sw, 32'h140, $random(seed));
        add_load("lw_140", rv32i_types::lw, 32'h140);
        add_store("sb_141", rv32i_types::sb, 32'h141, 32'h0000_009a);
        add_load("lbu_141", rv32i_types::lbu, 32'h141);
        add_store("sh_142", rv32i_types::sh, 32'h142, $random(seed));
        add_load("lh_142", rv32i_types::lh, 32'h142);
        add_load("lw_140_final", rv32i_types::lw, 32'h140);
        add_idle("tail");
    endtask

    task automatic check_value(input string name, input string field,
                               input rv32i_types::word_t expected,
                               input rv32i_types::word_t actual, inout bit ok);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s %s: expected %08h actual %08h",
                     name, field, expected, actual);
            errors = errors + 1;
            ok = 1'b0;
        end
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk)
    begin
        int idx;
        bit ok;
        if (!rst && table_ready)
        begin
            if (wb_done && pending.size() == 0)
            begin
                $display("wb_done went high in cycle %0d with no access in flight", cycle);
                errors = errors + 1;
            end
            else if (wb_done)
            begin
                idx = pending.pop_front();
                ok = 1'b1;
                check_value(op_name[idx], "done cycle", issue_cycle[idx] + 3, cycle, ok);
                check_value(op_name[idx], "wb_fault", {31'b0, exp_fault[idx]},
                            {31'b0, wb_fault}, ok);
                check_value(op_name[idx], "wb_data", exp_data[idx], wb_data, ok);
                checked = checked + 1;
                if (ok)
                    passed = passed + 1;
                else
                    failed = failed + 1;
                $display("%-20s %s", op_name[idx], ok ? "ok" : "mismatch");
            end
            else
            begin
                if (wb_fault)
                begin
                    $display("wb_fault went high without wb_done in cycle %0d", cycle);
                    errors = errors + 1;
                end
                if (pending.size() > 0 && cycle > issue_cycle[pending[0]] + 3)
                begin
                    idx = pending.pop_front();
                    $display("%s never got its wb_done", op_name[idx]);
                    errors = errors + 1;
                    failed = failed + 1;
                end
            end
        end
    end

    initial
    begin
        ex_valid = 1'b0;
        ex_load = 1'b0;
        ex_store = 1'b0;
        ex_funct3 = '0;
        alu_out = '0;
        rs2_out = '0;
        rst = 1'b1;
        cycle = 0;
        errors = 0;
        checked = 0;
        passed = 0;
        failed = 0;
        seed = 32'h41fbbcd6;
        build_table();
        build_expected();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < op_name.size(); i++)
        begin
            @(posedge clk);
            ex_valid <= op_load[i] || op_store[i];
            ex_load <= op_load[i];
            ex_store <= op_store[i];
            ex_funct3 <= op_f3[i];
            alu_out <= op_addr[i];
            rs2_out <= op_wdata[i];
            // cycle still holds the previous count here
            if (op_load[i] || op_store[i])
            begin
                issue_cycle[i] = cycle + 1;
                pending.push_back(i);
            end
        end
        @(posedge clk);
        ex_valid <= 1'b0;
        ex_load <= 1'b0;
        ex_store <= 1'b0;
        while (pending.size() > 0)
            @(posedge clk);
        // a few quiet cycles to catch stray strobes
        repeat (4) @(posedge clk);
        $display("%0d accesses checked, %0d passed, %0d failed, %0d errors",
                 checked, passed, failed, errors);
        if (errors == 0 && failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int limit;
        int waited;
        while (!table_ready)
            @(posedge clk);
        limit = op_name.size() + 20;
        waited = 0;
        while (waited < limit)
        begin
            @(posedge clk);
            waited = waited + 1;
        end
        $display("timeout, run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/rv32i_types.sv
logic/mem_ctrl_stage.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/writeback_align.sv
logic/mem_access_top.sv
dv/mem_access_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mem_access_tb
RTL_TOP    := mem_access_top
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
